// ==== vlog.f ====
+incdir+rtl
rtl/mini_rv_pkg.sv
rtl/apb_if.sv
rtl/rv_core.sv
rtl/apb_periph.sv
rtl/tx_fifo.sv
rtl/uart_tx.sv
rtl/mini_rv_soc.sv
sim/tb_mini_rv_soc.sv

// ==== sim/program_input.txt ====
// per test: n_handler n_main key irq_cycle n_expect (irq_cycle 0 = no irq)
// then handler words from address 0, main words from pc 44, expected tx bytes
// string_out
0 5 0 0 2
800000B7 04800113 00208023 06900113 00208023
48 69
// key_echo, lb of key then sb, addi -3 then sb
0 5 C3 0 2
800000B7 01008183 00308023 FFD18213 00408023
C3 C0
// fifo_burst, six sb back to back
0 13 0 0 6
800000B7 04100113 04200193 04300213 04400293 04500313 04600393
00208023 00308023 00408023 00508023 00608023 00708023
41 42 43 44 45 46
// irq_marker, handler sends 21 then mret
4 9 0 5 5
80000437 02100493 00940023 30200073
800000B7 06100113 00208023 06200113 00208023 06300113 00208023
06400113 00208023
61 21 62 63 64
// end of tests
0 0 0 0 0

// ==== sim/tb_mini_rv_soc.sv ====
`timescale 1ns/1ns
`include "mini_rv_defs.svh"

module tb_mini_rv_soc;
    localparam int frame_clks = 10 * `CLKS_PER_BIT;
    localparam int rom_words  = 64;
    localparam int main_base  = `RESET_PC / 4;   // rom index of first main word

    logic             clk;
    logic             reset;
    logic [`XLEN-1:0] instruction;
    logic [`XLEN-1:0] pc;
    logic [7:0]       key_in;
    logic             irq;
    logic             irq_done;
    logic             tx;

    logic [31:0] stim [0:255];           // raw words of the data file
    logic [31:0] rom  [0:rom_words-1];   // program image
    int          irq_at;                 // rise cycle, 0 = never
    int          cycle;                  // posedges since reset release
    int          done_count;             // irq_done pulses
    int          limit_cycles;
    int          error_count;
    int          test_count;
    int          failed_count;

    mini_rv_soc i_mini_rv_soc (
        .clk         (clk),
        .reset       (reset),
        .instruction (instruction),
        .pc          (pc),
        .key_in      (key_in),
        .irq         (irq),
        .irq_done    (irq_done),
        .tx          (tx)
    );

    always #10 clk = ~clk;

    // program port and irq, all on the falling edge
    always @(negedge clk) begin
        instruction <= (pc[31:2] < rom_words) ? rom[pc[31:2]] : '0;   // zeros past the image
        if (!reset) begin
            cycle      <= 0;
            done_count <= 0;
        end else begin
            cycle <= cycle + 1;
            if (irq_at != 0 && cycle + 1 == irq_at)
                irq <= 1'b1;
            if (irq_done) begin
                irq        <= 1'b0;      // handler acknowledged
                done_count <= done_count + 1;
            end
        end
    end

    function automatic string test_name(input int idx);
        case (idx)
            0: return "reset_idle";
            1: return "string_out";
            2: return "key_echo";
            3: return "fifo_burst";
            4: return "irq_marker";
            default: return $sformatf("test_%0d", idx);
        endcase
    endfunction

    // header counts are written in decimal, one digit per hex nibble
    function automatic int decimal_field(input logic [31:0] w);
        int v;
        int i;
        v = 0;
        for (i = 7; i >= 0; i--)
            v = v * 10 + w[4*i +: 4];
        return v;
    endfunction

    // frames plus program length per test
    function automatic int budget_cycles();
        int p;
        int total;
        int nh;
        int nm;
        int ne;
        p = 0;
        total = 10 * frame_clks;             // reset test and slack
        while (p < 250 && stim[p+1] != 0) begin
            nh = decimal_field(stim[p]);
            nm = decimal_field(stim[p+1]);
            ne = decimal_field(stim[p+4]);
            total += 5 + nh + nm + decimal_field(stim[p+3]) + (ne + 2) * frame_clks;
            p += 5 + nh + nm + ne;
        end
        return 2 * total;
    endfunction

    task automatic apply_reset(input string name, input logic [7:0] key, input int irq_cycle);
        reset  <= 1'b0;
        key_in <= key;
        irq    <= 1'b0;
        irq_at <= irq_cycle;
        repeat (5) @(negedge clk);
        if (pc !== `RESET_PC || tx !== 1'b1 || irq_done !== 1'b0) begin
            $display("CHECK FAILED %s reset: expected pc=%0d/tx=1/irq_done=0 actual %0d/%b/%b",
                     name, `RESET_PC, pc, tx, irq_done);
            error_count++;
        end
        reset <= 1'b1;                       // release on falling edge
    endtask

    // one 8N1 frame, sampled mid-bit
    task automatic receive_byte(output logic [7:0] data, output logic framing_ok);
        int i;
        data       = '0;
        framing_ok = 1'b1;
        @(negedge clk);
        while (tx !== 1'b0)
            @(negedge clk);
        repeat (`CLKS_PER_BIT / 2) @(negedge clk);
        if (tx !== 1'b0)
            framing_ok = 1'b0;               // start bit glitch
        for (i = 0; i < 8; i++) begin
            repeat (`CLKS_PER_BIT) @(negedge clk);
            data[i] = tx;                    // lsb first
        end
        repeat (`CLKS_PER_BIT) @(negedge clk);
        if (tx !== 1'b1)
            framing_ok = 1'b0;               // stop bit
    endtask

    // line must stay idle, catches extra or repeated bytes
    task automatic check_idle(input string name, input int cycles);
        int  k;
        logic seen;
        seen = 1'b0;
        for (k = 0; k < cycles; k++) begin
            @(negedge clk);
            if (tx !== 1'b1 && !seen) begin
                $display("%s: tx left idle after the last expected byte", name);
                error_count++;
                seen = 1'b1;
            end
        end
    endtask

    task automatic check_done(input string name, input int expected);
        if (done_count != expected) begin
            $display("CHECK FAILED %s irq_done pulses: expected %0d actual %0d",
                     name, expected, done_count);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_count++;
        if (error_count == errs_before) begin
            $display("PASS %s", name);
        end else begin
            failed_count++;
            $display("FAIL %s with %0d errors", name, error_count - errs_before);
        end
    endtask

    task automatic run_test(input int idx, inout int p);
        int          nh;
        int          nm;
        int          ne;
        int          irq_cycle;
        int          errs_before;
        int          k;
        logic [7:0]  key;
        logic [7:0]  got;
        logic        framing_ok;
        string       name;
        name      = test_name(idx);
        nh        = decimal_field(stim[p]);
        nm        = decimal_field(stim[p+1]);
        key       = stim[p+2][7:0];
        irq_cycle = decimal_field(stim[p+3]);
        ne        = decimal_field(stim[p+4]);
        p += 5;
        foreach (rom[i])
            rom[i] = '0;
        for (k = 0; k < nh; k++)
            rom[k] = stim[p+k];              // handler at the irq vector
        p += nh;
        for (k = 0; k < nm; k++)
            rom[main_base+k] = stim[p+k];
        p += nm;
        errs_before = error_count;
        apply_reset(name, key, irq_cycle);
        for (k = 0; k < ne; k++) begin
            receive_byte(got, framing_ok);
            if (!framing_ok) begin
                $display("%s byte %0d: start or stop bit had the wrong level", name, k);
                error_count++;
            end
            if (got !== stim[p+k][7:0]) begin
                $display("CHECK FAILED %s byte %0d: expected 0x%02h actual 0x%02h",
                         name, k, stim[p+k][7:0], got);
                error_count++;
            end
        end
        p += ne;
        check_idle(name, 2 * frame_clks);
        check_done(name, (irq_cycle != 0) ? 1 : 0);   // one pulse per handler
        report_test(name, errs_before);
    endtask

    initial begin
        limit_cycles = 0;
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: run did not finish within %0d clock cycles", limit_cycles);
        $display("tests failed");
        $finish;
    end

    initial begin
        int p;
        int idx;
        clk          = 1'b0;
        reset        = 1'b0;
        instruction  = '0;
        key_in       = '0;
        irq          = 1'b0;
        irq_at       = 0;
        error_count  = 0;
        test_count   = 0;
        failed_count = 0;
        $readmemh("sim/program_input.txt", stim);
        if (^stim[0] === 1'bx) begin
            $display("stimulus file sim/program_input.txt could not be read");
            $display("tests failed");
            $finish;
        end else begin
            limit_cycles = budget_cycles();
            // zero words only, nothing executes
            foreach (rom[i])
                rom[i] = '0;
            apply_reset(test_name(0), 8'h00, 0);
            check_idle(test_name(0), 2 * frame_clks);
            check_done(test_name(0), 0);
            report_test(test_name(0), 0);
            p   = 0;
            idx = 1;
            while (p < 250 && stim[p+1] != 0) begin
                run_test(idx, p);
                idx++;
            end
            $display("summary: %0d tests run, %0d with errors, %0d checks wrong",
                     test_count, failed_count, error_count);
            if (error_count == 0)
                $display("all tests passed");
            else
                $display("tests failed");
            $finish;
        end
    end

endmodule

// ==== rtl/mini_rv_soc.sv ====
`timescale 1ns/1ns
`include "mini_rv_defs.svh"

module mini_rv_soc (
    input  logic             clk,
    input  logic             reset,
    input  logic [`XLEN-1:0] instruction,   // program port
    output logic [`XLEN-1:0] pc,
    input  logic [7:0]       key_in,
    input  logic             irq,
    output logic             irq_done,
    output logic             tx
);
    apb_if i_apb_if ();

    // fifo write side
    logic       push;
    logic [7:0] push_data;
    logic       full;
    // fifo read side
    logic       pop;
    logic [7:0] pop_data;
    logic       empty;

    rv_core i_rv_core (
        .clk         (clk),
        .reset       (reset),
        .instruction (instruction),
        .pc          (pc),
        .irq         (irq),
        .irq_done    (irq_done),
        .bus         (i_apb_if.master)
    );

    apb_periph i_apb_periph (
        .clk       (clk),
        .reset     (reset),
        .bus       (i_apb_if.slave),
        .key_in    (key_in),
        .push      (push),
        .push_data (push_data),
        .full      (full)      // back-pressure into pready
    );

    tx_fifo i_tx_fifo (
        .clk       (clk),
        .reset     (reset),
        .push      (push),
        .push_data (push_data),
        .full      (full),
        .pop       (pop),
        .pop_data  (pop_data),
        .empty     (empty)
    );

    uart_tx i_uart_tx (
        .clk      (clk),
        .reset    (reset),
        .pop      (pop),
        .pop_data (pop_data),
        .empty    (empty),
        .tx       (tx)
    );

endmodule

// ==== rtl/uart_tx.sv ====
`timescale 1ns/1ns
`include "mini_rv_defs.svh"

module uart_tx (
    input  logic       clk,
    input  logic       reset,
    output logic       pop,        // take head byte from fifo
    input  logic [7:0] pop_data,
    input  logic       empty,
    output logic       tx          // serial line, idles high
);
    localparam int cw = $clog2(`CLKS_PER_BIT);

    logic          busy;
    logic [8:0]    shifter;        // {stop, data}, shifted out lsb first
    logic [3:0]    bit_idx;        // 0 start, 1..8 data, 9 stop
    logic [cw-1:0] clk_cnt;        // bit time counter

    assign pop = !busy && !empty;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            busy    <= 1'b0;
            tx      <= 1'b1;
            shifter <= '0;
            bit_idx <= '0;
            clk_cnt <= '0;
        end else if (!busy) begin
            if (!empty) begin
                busy    <= 1'b1;
                shifter <= {1'b1, pop_data};
                tx      <= 1'b0;           // start bit
                bit_idx <= '0;
                clk_cnt <= '0;
            end
        end else if (clk_cnt == cw'(`CLKS_PER_BIT-1)) begin
            clk_cnt <= '0;
            if (bit_idx == 4'd9) begin
                busy <= 1'b0;              // stop bit done, back to idle
            end else begin
                tx      <= shifter[0];
                shifter <= shifter >> 1;
                bit_idx <= bit_idx + 4'd1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

endmodule

// ==== rtl/tx_fifo.sv ====
`timescale 1ns/1ns
`include "mini_rv_defs.svh"

module tx_fifo (
    input  logic       clk,
    input  logic       reset,
    input  logic       push,
    input  logic [7:0] push_data,
    output logic       full,
    input  logic       pop,
    output logic [7:0] pop_data,    // head byte, valid when not empty
    output logic       empty
);
    localparam int aw = $clog2(`FIFO_DEPTH);

    logic [7:0]    mem [0:`FIFO_DEPTH-1];
    logic [aw-1:0] rd_ptr;
    logic [aw-1:0] wr_ptr;
    logic [aw:0]   count;           // needs one more bit than the pointers
    logic          do_push;
    logic          do_pop;

    assign full     = count == (aw+1)'(`FIFO_DEPTH);
    assign empty    = count == '0;
    assign do_push  = push && !full;     // extra pushes dropped
    assign do_pop   = pop && !empty;
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= (wr_ptr == aw'(`FIFO_DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == aw'(`FIFO_DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            count <= count + (aw+1)'(do_push) - (aw+1)'(do_pop);  // both = no change
        end
    end

endmodule

// ==== rtl/apb_periph.sv ====
`timescale 1ns/1ns
`include "mini_rv_defs.svh"

module apb_periph (
    input  logic       clk,
    input  logic       reset,
    apb_if.slave       bus,
    input  logic [7:0] key_in,      // external, not aligned to clk
    output logic       push,        // fifo write strobe
    output logic [7:0] push_data,
    input  logic       full
);
    localparam logic [`XLEN-1:0] periph_base = `PERIPH_BASE;

    logic region_hit;
    logic tx_hit;
    logic key_hit;
    logic tx_write;

    // region = upper bits, register = low byte of address
    assign region_hit = bus.paddr[`XLEN-1:8] == periph_base[`XLEN-1:8];
    assign tx_hit     = region_hit && bus.paddr[7:0] == 8'(`TX_OFFSET);
    assign key_hit    = region_hit && bus.paddr[7:0] == 8'(`KEY_OFFSET);
    assign tx_write   = tx_hit && bus.pwrite;

    // transmit waits on a full fifo, the rest completes at once
    assign bus.pready = tx_write ? !full : 1'b1;

    // one push, on the completing edge only
    assign push      = bus.psel && bus.penable && tx_write && !full;
    assign push_data = bus.pwdata[7:0];

    // read data captured in setup, valid through access
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            bus.prdata <= '0;
        end else if (bus.psel && !bus.penable) begin
            if (key_hit && !bus.pwrite)
                bus.prdata <= {{(`XLEN-8){1'b0}}, key_in};  // zero extended
            else
                bus.prdata <= '0;   // unmapped or write
        end
    end

endmodule

// ==== rtl/rv_core.sv ====
`timescale 1ns/1ns
`include "mini_rv_defs.svh"

module rv_core (
    input  logic             clk,
    input  logic             reset,
    input  logic [`XLEN-1:0] instruction,  // word at pc
    output logic [`XLEN-1:0] pc,
    input  logic             irq,          // level sensitive
    output logic             irq_done,     // one cycle after mret
    apb_if.master            bus
);
    mini_rv_pkg::inst_u ir;             // fetch register
    logic               bubble;         // ir holds a flushed word
    logic               in_access;      // apb access phase open
    logic               in_handler;
    logic [`XLEN-1:0]   ret_pc;         // saved return address

    logic [`XLEN-1:0]   regs [0:31];
    logic [4:0]         rd;
    logic [4:0]         rs1;
    logic [4:0]         rs2;
    logic [`XLEN-1:0]   rs1_val;
    logic [`XLEN-1:0]   rs2_val;
    logic [`XLEN-1:0]   imm_u;
    logic [`XLEN-1:0]   imm_i;
    logic [`XLEN-1:0]   imm_s;

    logic               f3_zero;
    logic               is_lui;
    logic               is_addi;
    logic               is_lb;
    logic               is_sb;
    logic               is_mret;
    logic               take_irq;
    logic               mem_op;
    logic               rf_we;
    logic [`XLEN-1:0]   rf_wd;

    assign rd  = ir.u_fmt.rd;          // same bits as imm_b_rd
    assign rs1 = ir.is_fmt.rs1;
    assign rs2 = ir.is_fmt.rs2;

    // x0 reads as zero
    assign rs1_val = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == 5'd0) ? '0 : regs[rs2];

    // immediates
    assign imm_u = {ir.u_fmt.imm_hi, 12'b0};
    assign imm_i = {{(`XLEN-12){ir.is_fmt.imm_a[6]}}, ir.is_fmt.imm_a, ir.is_fmt.rs2};
    assign imm_s = {{(`XLEN-12){ir.is_fmt.imm_a[6]}}, ir.is_fmt.imm_a, ir.is_fmt.imm_b_rd};

    // decode, nothing executes from a flushed word
    assign f3_zero = ir.is_fmt.funct3 == 3'b000;   // addi, lb, sb, mret
    assign is_lui  = !bubble && ir.u_fmt.opcode == mini_rv_pkg::lui;
    assign is_addi = !bubble && ir.is_fmt.opcode == mini_rv_pkg::op_imm && f3_zero;
    assign is_lb   = !bubble && ir.is_fmt.opcode == mini_rv_pkg::load && f3_zero;
    assign is_sb   = !bubble && ir.is_fmt.opcode == mini_rv_pkg::store && f3_zero;
    assign is_mret = !bubble && ir.is_fmt.opcode == mini_rv_pkg::system && f3_zero
                     && {ir.is_fmt.imm_a, ir.is_fmt.rs2} == 12'h302;

    // irq wins over the word in ir, never inside a transfer
    assign take_irq = irq && !in_handler && !in_access && !bubble;
    assign mem_op   = (is_lb || is_sb) && !take_irq;

    // apb master, setup while idle, access after
    assign bus.psel    = mem_op;
    assign bus.penable = in_access;
    assign bus.pwrite  = is_sb;
    assign bus.paddr   = rs1_val + (is_sb ? imm_s : imm_i);
    assign bus.pwdata  = rs2_val;                   // low byte used

    // register file write port
    always_comb begin
        rf_we = 1'b0;
        rf_wd = imm_u;
        if (!take_irq) begin
            if (is_lui) begin
                rf_we = 1'b1;
            end else if (is_addi) begin
                rf_we = 1'b1;
                rf_wd = rs1_val + imm_i;
            end else if (is_lb && in_access && bus.pready) begin
                rf_we = 1'b1;
                rf_wd = {{(`XLEN-8){bus.prdata[7]}}, bus.prdata[7:0]}; // sign extend
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rf_we && rd != 5'd0)
            regs[rd] <= rf_wd;
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc         <= `RESET_PC;
            ir         <= '0;
            bubble     <= 1'b1;         // zero word is not executed
            in_access  <= 1'b0;
            in_handler <= 1'b0;
            ret_pc     <= '0;
            irq_done   <= 1'b0;
        end else begin
            irq_done <= 1'b0;
            if (take_irq) begin
                ret_pc     <= pc - `XLEN'(4);   // re-run the skipped word
                in_handler <= 1'b1;
                pc         <= `IRQ_VECTOR;
                ir         <= instruction;
                bubble     <= 1'b1;             // flush stale fetch
            end else if (mem_op) begin
                // pc and ir held until the transfer completes
                if (!in_access) begin
                    in_access <= 1'b1;
                end else if (bus.pready) begin
                    in_access <= 1'b0;
                    pc        <= pc + `XLEN'(4);
                    ir        <= instruction;
                end
            end else if (is_mret) begin
                pc         <= ret_pc;
                in_handler <= 1'b0;
                irq_done   <= 1'b1;
                ir         <= instruction;
                bubble     <= 1'b1;
            end else begin
                pc     <= pc + `XLEN'(4);    // lui, addi, bubble, unknown
                ir     <= instruction;
                bubble <= 1'b0;
            end
        end
    end

endmodule

// ==== rtl/apb_if.sv ====
`timescale 1ns/1ns
`include "mini_rv_defs.svh"

interface apb_if;
    logic             psel;
    logic             penable;     // high from the second cycle on
    logic             pwrite;
    logic [`XLEN-1:0] paddr;
    logic [`XLEN-1:0] pwdata;
    logic [`XLEN-1:0] prdata;      // valid on the completing cycle
    logic             pready;      // low = wait state

    // core side
    modport master (output psel, penable, pwrite, paddr, pwdata,
                    input  prdata, pready);

    // peripheral side
    modport slave  (input  psel, penable, pwrite, paddr, pwdata,
                    output prdata, pready);

endinterface

// ==== rtl/mini_rv_pkg.sv ====
package mini_rv_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        lui    = 7'b0110111,
        op_imm = 7'b0010011,  // addi only
        load   = 7'b0000011,  // lb only
        store  = 7'b0100011,  // sb only
        system = 7'b1110011   // mret only
    } opcode_e;

    // upper immediate layout
    typedef struct packed {
        logic [19:0] imm_hi;
        logic [4:0]  rd;
        opcode_e     opcode;
    } u_fmt_t;

    // shared I/S layout
    // I imm = {imm_a, rs2}, S imm = {imm_a, imm_b_rd}
    typedef struct packed {
        logic [6:0] imm_a;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_b_rd;    // rd for I, low imm for S
        opcode_e    opcode;
    } is_fmt_t;

    // one fetched word, two views
    typedef union packed {
        u_fmt_t  u_fmt;
        is_fmt_t is_fmt;
    } inst_u;

endpackage

// ==== rtl/mini_rv_defs.svh ====
`ifndef MINI_RV_DEFS_SVH
`define MINI_RV_DEFS_SVH

// core data path
`define XLEN         32
`define RESET_PC     32'd44          // first fetch after reset
`define IRQ_VECTOR   32'd0           // external irq handler entry

// peripheral region, upper address plus byte offsets
`define PERIPH_BASE  32'h8000_0000
`define TX_OFFSET    0               // transmit data, write only
`define KEY_OFFSET   16              // key value, read only

// transmit path
`define FIFO_DEPTH   4               // bytes queued ahead of the serializer
`define CLKS_PER_BIT 8               // serial bit time

`endif
